// File: ddr_phy_rd_timing.f
common/ddr_phy_rd_timing_pkg.sv
verilog/lat_ctl_sync.sv
verilog/latency_dpram.sv
postamble/postamble_ctl.sv
verilog/rdata_valid_ctl.sv
verilog/ddr_phy_rd_timing.sv
sim/rd_timing_checker.sv
sim/tb_ddr_phy_rd_timing.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the read timing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ddr_phy_rd_timing -f ddr_phy_rd_timing.f \
    || { echo "run_sim: build failed"; exit 1; }

sim_out=$(./obj_dir/Vtb_ddr_phy_rd_timing 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "SIMULATION PASSED" \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// File: sim/tb_ddr_phy_rd_timing.sv
module tb_ddr_phy_rd_timing;
    timeunit 1ns;
    timeprecision 1ps;
    import ddr_phy_rd_timing_pkg::*;

    localparam int STEP_NONE     = 0;
    localparam int STEP_INC      = 1;
    localparam int STEP_DEC      = 2;
    localparam int PAT_RAND      = 0;
    localparam int PAT_ONES      = 1;
    localparam int NUM_ROWS      = 16;
    localparam int QUIET_CYCLES  = 80;  // longer than one trip around the RAM
    localparam int DRAIN_TIMEOUT = 64;

    // one stimulus row with the expected delays after its step
    typedef struct packed {
        int poa_step;
        int rdv_step;
        int ovr;
        int len;
        int pat;
        int poa_dly;
        int rdv_dly;
    } row_t;

    logic             phy_clk_1x;
    logic             reset_phy_clk_1x_n;
    logic             seq_poa_lat_inc_1x;
    logic             seq_poa_lat_dec_1x;
    logic             seq_poa_protection_override_1x;
    logic             seq_rdv_lat_inc_1x;
    logic             seq_rdv_lat_dec_1x;
    logic [BEATS-1:0] ctl_doing_rd_beat;
    logic [BEATS-1:0] poa_postamble_en_preset;
    logic [BEATS-1:0] ctl_rdata_valid;

    row_t        rows [NUM_ROWS];
    logic        beat_hist[$];   // every driven beat in order
    logic        force_hist[$];  // beats forced on by the override
    int          cyc = 0;
    logic        check_en = 1'b0;
    int          poa_dly = 2 * POA_INITIAL_LAT + 1;  // in beats
    int          rdv_dly = 2 * RDV_INITIAL_LAT;
    logic [31:0] lcg_state = 32'd98830;

    ddr_phy_rd_timing ddr_phy_rd_timing_inst (
        .phy_clk_1x                     (phy_clk_1x),
        .reset_phy_clk_1x_n             (reset_phy_clk_1x_n),
        .seq_poa_lat_inc_1x             (seq_poa_lat_inc_1x),
        .seq_poa_lat_dec_1x             (seq_poa_lat_dec_1x),
        .seq_poa_protection_override_1x (seq_poa_protection_override_1x),
        .seq_rdv_lat_inc_1x             (seq_rdv_lat_inc_1x),
        .seq_rdv_lat_dec_1x             (seq_rdv_lat_dec_1x),
        .ctl_doing_rd_beat              (ctl_doing_rd_beat),
        .poa_postamble_en_preset        (poa_postamble_en_preset),
        .ctl_rdata_valid                (ctl_rdata_valid)
    );

    initial
    begin
        phy_clk_1x = 1'b0;
        forever #2 phy_clk_1x = ~phy_clk_1x;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic expected_beat(input int idx, input logic with_force);
        if (idx < 0)
        begin
            return 1'b0;  // before the first driven beat
        end
        if (with_force)
        begin
            return beat_hist[idx] | force_hist[idx];
        end
        return beat_hist[idx];
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic load_table();
        rows[0]  = '{STEP_NONE, STEP_NONE, 0, 8,  PAT_RAND, 27, 30};
        rows[1]  = '{STEP_NONE, STEP_NONE, 0, 6,  PAT_ONES, 27, 30};
        rows[2]  = '{STEP_INC,  STEP_NONE, 0, 8,  PAT_RAND, 28, 30};  // from order 1
        rows[3]  = '{STEP_INC,  STEP_NONE, 0, 8,  PAT_RAND, 29, 30};  // from order 0
        rows[4]  = '{STEP_DEC,  STEP_NONE, 0, 8,  PAT_RAND, 28, 30};
        rows[5]  = '{STEP_DEC,  STEP_NONE, 0, 8,  PAT_RAND, 27, 30};
        rows[6]  = '{STEP_DEC,  STEP_NONE, 0, 8,  PAT_RAND, 26, 30};
        rows[7]  = '{STEP_INC,  STEP_NONE, 0, 8,  PAT_RAND, 27, 30};
        rows[8]  = '{STEP_NONE, STEP_INC,  0, 8,  PAT_RAND, 27, 32};
        rows[9]  = '{STEP_NONE, STEP_INC,  0, 8,  PAT_RAND, 27, 34};
        rows[10] = '{STEP_NONE, STEP_DEC,  0, 8,  PAT_RAND, 27, 32};
        rows[11] = '{STEP_INC,  STEP_DEC,  0, 8,  PAT_RAND, 28, 30};
        rows[12] = '{STEP_NONE, STEP_NONE, 1, 5,  PAT_ONES, 28, 30};  // override with even delay
        rows[13] = '{STEP_DEC,  STEP_NONE, 0, 8,  PAT_RAND, 27, 30};
        rows[14] = '{STEP_NONE, STEP_NONE, 1, 4,  PAT_ONES, 27, 30};  // override with odd delay
        rows[15] = '{STEP_NONE, STEP_NONE, 0, 10, PAT_ONES, 27, 30};
    endtask

    // outputs seen at falling edge n belong to beats driven one cycle earlier
    task automatic compare_outputs(input int n);
        logic [BEATS-1:0] exp_poa;
        logic [BEATS-1:0] exp_rdv;
        for (int s = 0; s < BEATS; s++)
        begin
            exp_poa[s] = expected_beat(2 * n + s - poa_dly - 2, 1'b1);
            exp_rdv[s] = expected_beat(2 * n + s - rdv_dly - 2, 1'b0);
        end
        assert (poa_postamble_en_preset == exp_poa)
        else stop_on_error($sformatf(
            "ERR poa_postamble_en_preset cycle %0d expected 0x%h actual 0x%h",
            n, exp_poa, poa_postamble_en_preset));
        assert (ctl_rdata_valid == exp_rdv)
        else stop_on_error($sformatf(
            "ERR ctl_rdata_valid cycle %0d expected 0x%h actual 0x%h",
            n, exp_rdv, ctl_rdata_valid));
    endtask

    task automatic run_cycle(input logic [BEATS-1:0] beats, input logic ovr,
                             input logic poa_inc, input logic poa_dec,
                             input logic rdv_inc, input logic rdv_dec);
        int n;
        @(negedge phy_clk_1x);
        n = cyc;
        if (check_en)
        begin
            compare_outputs(n);
        end
        ctl_doing_rd_beat              = beats;
        seq_poa_protection_override_1x = ovr;
        seq_poa_lat_inc_1x             = poa_inc;
        seq_poa_lat_dec_1x             = poa_dec;
        seq_rdv_lat_inc_1x             = rdv_inc;
        seq_rdv_lat_dec_1x             = rdv_dec;
        for (int b = 0; b < BEATS; b++)
        begin
            beat_hist.push_back(beats[b]);
            force_hist.push_back(1'b0);
        end
        if (ovr)
        begin
            // odd delay puts the previous cycle's beat 1 in the same word
            if (poa_dly % 2 != 0)
            begin
                if (n > 0)
                begin
                    force_hist[2 * n - 1] = 1'b1;
                end
                force_hist[2 * n] = 1'b1;
            end
            else
            begin
                force_hist[2 * n]     = 1'b1;
                force_hist[2 * n + 1] = 1'b1;
            end
        end
        cyc++;
    endtask

    task automatic apply_row(input row_t r);
        logic [BEATS-1:0] beats;
        int               last_idx;
        int               waited;
        int               max_dly;
        logic             done;
        run_cycle('0, 1'b0, r.poa_step == STEP_INC, r.poa_step == STEP_DEC,
                  r.rdv_step == STEP_INC, r.rdv_step == STEP_DEC);  // one-cycle level

        // delays in beats that hold once this row's step has settled
        poa_dly = r.poa_dly;
        rdv_dly = r.rdv_dly;

        // let the pipeline refill after the step
        for (int i = 0; i < QUIET_CYCLES; i++)
        begin
            run_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end

        check_en = 1'b1;
        for (int i = 0; i < r.len; i++)
        begin
            if (r.ovr != 0)
            begin
                beats = '0;  // override during a quiet period
            end
            else if (r.pat == PAT_ONES)
            begin
                beats = '1;
            end
            else
            begin
                lcg_state = lcg_next(lcg_state);
                beats     = lcg_state[17:16];
            end
            run_cycle(beats, r.ovr != 0, 1'b0, 1'b0, 1'b0, 1'b0);
        end

        last_idx = 2 * cyc - 1;
        max_dly  = (poa_dly > rdv_dly) ? poa_dly : rdv_dly;
        waited   = 0;
        done     = 1'b0;
        while (!done)
        begin
            if (waited >= DRAIN_TIMEOUT)
            begin
                stop_on_error("burst did not leave the delay lines before the timeout");
            end
            else
            begin
                run_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
                waited++;
                done = (2 * (cyc - 1) - 1 - max_dly) >= last_idx;
            end
        end
        check_en = 1'b0;
    endtask

    initial
    begin
        reset_phy_clk_1x_n             = 1'b0;
        seq_poa_lat_inc_1x             = 1'b0;
        seq_poa_lat_dec_1x             = 1'b0;
        seq_poa_protection_override_1x = 1'b0;
        seq_rdv_lat_inc_1x             = 1'b0;
        seq_rdv_lat_dec_1x             = 1'b0;
        ctl_doing_rd_beat              = '0;
        load_table();

        for (int i = 0; i < 8; i++)
        begin
            run_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        reset_phy_clk_1x_n = 1'b1;

        // both outputs stay low until a burst arrives
        check_en = 1'b1;
        for (int i = 0; i < 40; i++)
        begin
            run_cycle('0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        check_en = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            apply_row(rows[i]);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sim/rd_timing_checker.sv
module rd_timing_checker (
    input  logic                                         phy_clk_1x,
    input  logic                                         reset_phy_clk_1x_n,
    input  logic                                         inc_pulse,
    input  logic                                         dec_pulse,
    input  logic                                         bit_order,
    input  logic [ddr_phy_rd_timing_pkg::LAT_AWIDTH-1:0] wr_addr,
    input  logic [ddr_phy_rd_timing_pkg::LAT_AWIDTH-1:0] rd_addr
);
    timeunit 1ns;
    timeprecision 1ps;
    import ddr_phy_rd_timing_pkg::*;

    logic [LAT_AWIDTH-1:0] ptr_dist;

    assign ptr_dist = wr_addr - rd_addr;  // modulo RAM depth

    pulses_exclusive: assert property (
        @(posedge phy_clk_1x) disable iff (!reset_phy_clk_1x_n)
        !(inc_pulse && dec_pulse))
    else $error("inc_pulse and dec_pulse high in the same cycle");

    // first edge after reset release still sees the reset bit order
    order_after_reset: assert property (
        @(posedge phy_clk_1x)
        $rose(reset_phy_clk_1x_n) |-> bit_order)
    else $error("bit_order not 1 after reset release");

    ptr_distance_range: assert property (
        @(posedge phy_clk_1x) disable iff (!reset_phy_clk_1x_n)
        (ptr_dist >= LAT_AWIDTH'(2)) && (ptr_dist <= LAT_AWIDTH'(62)))
    else $error("write to read pointer distance %0d out of range", ptr_dist);

endmodule

bind postamble_ctl rd_timing_checker rd_timing_checker_inst (
    .phy_clk_1x         (phy_clk_1x),
    .reset_phy_clk_1x_n (reset_phy_clk_1x_n),
    .inc_pulse          (inc_pulse),
    .dec_pulse          (dec_pulse),
    .bit_order          (bit_order),
    .wr_addr            (wr_addr),
    .rd_addr            (rd_addr)
);

// File: verilog/ddr_phy_rd_timing.sv
module ddr_phy_rd_timing (
    input  logic                                    phy_clk_1x,
    input  logic                                    reset_phy_clk_1x_n,

    // sequencer calibration levels
    input  logic                                    seq_poa_lat_inc_1x,
    input  logic                                    seq_poa_lat_dec_1x,
    input  logic                                    seq_poa_protection_override_1x,
    input  logic                                    seq_rdv_lat_inc_1x,
    input  logic                                    seq_rdv_lat_dec_1x,

    // from the controller, bit 0 is the earlier beat
    input  logic [ddr_phy_rd_timing_pkg::BEATS-1:0] ctl_doing_rd_beat,

    output logic [ddr_phy_rd_timing_pkg::BEATS-1:0] poa_postamble_en_preset,  // to DQS capture
    output logic [ddr_phy_rd_timing_pkg::BEATS-1:0] ctl_rdata_valid           // to controller
);

    // postamble enable, half-cycle adjustable
    postamble_ctl postamble_ctl_inst (
        .phy_clk_1x                     (phy_clk_1x),
        .reset_phy_clk_1x_n             (reset_phy_clk_1x_n),
        .seq_poa_lat_inc_1x             (seq_poa_lat_inc_1x),
        .seq_poa_lat_dec_1x             (seq_poa_lat_dec_1x),
        .seq_poa_protection_override_1x (seq_poa_protection_override_1x),
        .ctl_doing_rd_beat              (ctl_doing_rd_beat),
        .poa_postamble_en_preset        (poa_postamble_en_preset)
    );

    // read data valid, whole-cycle adjustable
    rdata_valid_ctl rdata_valid_ctl_inst (
        .phy_clk_1x         (phy_clk_1x),
        .reset_phy_clk_1x_n (reset_phy_clk_1x_n),
        .seq_rdv_lat_inc_1x (seq_rdv_lat_inc_1x),
        .seq_rdv_lat_dec_1x (seq_rdv_lat_dec_1x),
        .ctl_doing_rd_beat  (ctl_doing_rd_beat),
        .ctl_rdata_valid    (ctl_rdata_valid)
    );

endmodule

// File: verilog/rdata_valid_ctl.sv
module rdata_valid_ctl (
    input  logic                                    phy_clk_1x,
    input  logic                                    reset_phy_clk_1x_n,
    input  logic                                    seq_rdv_lat_inc_1x,
    input  logic                                    seq_rdv_lat_dec_1x,
    input  logic [ddr_phy_rd_timing_pkg::BEATS-1:0] ctl_doing_rd_beat,
    output logic [ddr_phy_rd_timing_pkg::BEATS-1:0] ctl_rdata_valid
);
    import ddr_phy_rd_timing_pkg::*;

    logic                  inc_pulse;
    logic                  dec_pulse;
    logic [LAT_AWIDTH-1:0] wr_addr;
    logic [LAT_AWIDTH-1:0] next_wr_addr;
    logic [LAT_AWIDTH-1:0] rd_addr;

    lat_ctl_sync lat_ctl_sync_inst (
        .phy_clk_1x         (phy_clk_1x),
        .reset_phy_clk_1x_n (reset_phy_clk_1x_n),
        .lat_inc            (seq_rdv_lat_inc_1x),
        .lat_dec            (seq_rdv_lat_dec_1x),
        .inc_pulse          (inc_pulse),
        .dec_pulse          (dec_pulse)
    );

    // whole-cycle steps only
    always_comb
    begin
        if (dec_pulse)
        begin
            next_wr_addr = wr_addr;
        end
        else if (inc_pulse)
        begin
            next_wr_addr = wr_addr + LAT_AWIDTH'(2);
        end
        else
        begin
            next_wr_addr = wr_addr + LAT_AWIDTH'(1);
        end
    end

    always_ff @(posedge phy_clk_1x or negedge reset_phy_clk_1x_n)
    begin
        if (!reset_phy_clk_1x_n)
        begin
            wr_addr <= LAT_AWIDTH'(RDV_INITIAL_LAT);
            rd_addr <= '0;
        end
        else
        begin
            wr_addr <= next_wr_addr;
            rd_addr <= rd_addr + LAT_AWIDTH'(1);
        end
    end

    // beats are stored unshifted
    latency_dpram latency_dpram_inst (
        .phy_clk_1x (phy_clk_1x),
        .wr_addr    (wr_addr),
        .wr_data    (ctl_doing_rd_beat),
        .rd_addr    (rd_addr),
        .rd_data    (ctl_rdata_valid)
    );

endmodule

// File: postamble/postamble_ctl.sv
module postamble_ctl (
    input  logic                                    phy_clk_1x,
    input  logic                                    reset_phy_clk_1x_n,
    input  logic                                    seq_poa_lat_inc_1x,
    input  logic                                    seq_poa_lat_dec_1x,
    input  logic                                    seq_poa_protection_override_1x,
    input  logic [ddr_phy_rd_timing_pkg::BEATS-1:0] ctl_doing_rd_beat,
    output logic [ddr_phy_rd_timing_pkg::BEATS-1:0] poa_postamble_en_preset
);
    import ddr_phy_rd_timing_pkg::*;

    logic                  inc_pulse;
    logic                  dec_pulse;
    logic [LAT_AWIDTH-1:0] wr_addr;
    logic [LAT_AWIDTH-1:0] next_wr_addr;
    logic [LAT_AWIDTH-1:0] rd_addr;
    logic [BEATS-1:0]      wr_data;
    logic                  bit_order;   // 1 = word straddles two cycles
    logic                  beat1_r;     // later beat of the previous cycle

    lat_ctl_sync lat_ctl_sync_inst (
        .phy_clk_1x         (phy_clk_1x),
        .reset_phy_clk_1x_n (reset_phy_clk_1x_n),
        .lat_inc            (seq_poa_lat_inc_1x),
        .lat_dec            (seq_poa_lat_dec_1x),
        .inc_pulse          (inc_pulse),
        .dec_pulse          (dec_pulse)
    );

    // word written into the delay RAM
    always_comb
    begin
        if (seq_poa_protection_override_1x)
        begin
            wr_data = POA_OVERRIDE_VAL;  // force enable on
        end
        else if (!bit_order)
        begin
            wr_data = ctl_doing_rd_beat;
        end
        else
        begin
            // half-cycle shift, previous beat 1 goes first
            wr_data = {ctl_doing_rd_beat[0], beat1_r};
        end
    end

    // half-cycle steps come from the bit order flip, whole cycles
    // from moving the write pointer
    always_comb
    begin
        next_wr_addr = wr_addr + LAT_AWIDTH'(1);
        if (dec_pulse)
        begin
            if (!bit_order)
            begin
                next_wr_addr = wr_addr;  // hold, one cycle less
            end
        end
        else if (inc_pulse)
        begin
            if (bit_order)
            begin
                next_wr_addr = wr_addr + LAT_AWIDTH'(2);
            end
        end
    end

    always_ff @(posedge phy_clk_1x or negedge reset_phy_clk_1x_n)
    begin
        if (!reset_phy_clk_1x_n)
        begin
            wr_addr   <= LAT_AWIDTH'(POA_INITIAL_LAT);
            rd_addr   <= '0;
            bit_order <= 1'b1;
            beat1_r   <= 1'b0;
        end
        else
        begin
            wr_addr <= next_wr_addr;
            rd_addr <= rd_addr + LAT_AWIDTH'(1);  // free running, wraps
            beat1_r <= ctl_doing_rd_beat[BEATS-1];
            if (inc_pulse || dec_pulse)
            begin
                bit_order <= ~bit_order;  // every step moves half a cycle
            end
        end
    end

    latency_dpram latency_dpram_inst (
        .phy_clk_1x (phy_clk_1x),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .rd_addr    (rd_addr),
        .rd_data    (poa_postamble_en_preset)
    );

endmodule

// File: verilog/latency_dpram.sv
module latency_dpram (
    input  logic                                         phy_clk_1x,
    input  logic [ddr_phy_rd_timing_pkg::LAT_AWIDTH-1:0] wr_addr,
    input  logic [ddr_phy_rd_timing_pkg::BEATS-1:0]      wr_data,
    input  logic [ddr_phy_rd_timing_pkg::LAT_AWIDTH-1:0] rd_addr,
    output logic [ddr_phy_rd_timing_pkg::BEATS-1:0]      rd_data
);
    import ddr_phy_rd_timing_pkg::*;

    localparam int DEPTH = 2 ** LAT_AWIDTH;

    // one beat word per address, powers up cleared
    logic [BEATS-1:0] mem [0:DEPTH-1] = '{default: '0};

    // write port is enabled every cycle
    always_ff @(posedge phy_clk_1x)
    begin
        mem[wr_addr] <= wr_data;
    end

    // registered read, data one cycle after the address
    always_ff @(posedge phy_clk_1x)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/lat_ctl_sync.sv
module lat_ctl_sync (
    input  logic phy_clk_1x,
    input  logic reset_phy_clk_1x_n,
    input  logic lat_inc,
    input  logic lat_dec,
    output logic inc_pulse,
    output logic dec_pulse
);
    import ddr_phy_rd_timing_pkg::*;

    logic inc_sync;
    logic dec_sync;
    logic inc_sync_d;  // previous synchronized level, for edge detect
    logic dec_sync_d;
    logic inc_rise;
    logic dec_rise;

    generate
        if (LAT_CTL_RESYNC != 0)
        begin : g_resync
            logic inc_meta;
            logic dec_meta;

            // two-flop synchronizer per level
            always_ff @(posedge phy_clk_1x or negedge reset_phy_clk_1x_n)
            begin
                if (!reset_phy_clk_1x_n)
                begin
                    inc_meta <= 1'b0;
                    dec_meta <= 1'b0;
                    inc_sync <= 1'b0;
                    dec_sync <= 1'b0;
                end
                else
                begin
                    inc_meta <= lat_inc;
                    dec_meta <= lat_dec;
                    inc_sync <= inc_meta;
                    dec_sync <= dec_meta;
                end
            end
        end
        else
        begin : g_direct
            assign inc_sync = lat_inc;  // levels already in this domain
            assign dec_sync = lat_dec;
        end
    endgenerate

    assign inc_rise = inc_sync & ~inc_sync_d;
    assign dec_rise = dec_sync & ~dec_sync_d;

    always_ff @(posedge phy_clk_1x or negedge reset_phy_clk_1x_n)
    begin
        if (!reset_phy_clk_1x_n)
        begin
            inc_sync_d <= 1'b0;
            dec_sync_d <= 1'b0;
            inc_pulse  <= 1'b0;
            dec_pulse  <= 1'b0;
        end
        else
        begin
            inc_sync_d <= inc_sync;
            dec_sync_d <= dec_sync;
            dec_pulse  <= dec_rise;
            inc_pulse  <= inc_rise & ~dec_rise;  // decrement wins a tie
        end
    end

endmodule

// File: common/ddr_phy_rd_timing_pkg.sv
package ddr_phy_rd_timing_pkg;

    // half-rate PHY, two memory beats per phy_clk_1x cycle
    localparam int DWIDTH_RATIO = 4;
    localparam int BEATS        = DWIDTH_RATIO / 2;  // width of every beat word

    // delay RAM address width, 64 words deep
    localparam int LAT_AWIDTH = 6;

    // reset distance between write and read pointers, in cycles
    localparam int POA_INITIAL_LAT = 13;
    localparam int RDV_INITIAL_LAT = 15;

    // postamble word while the sequencer protection override is high
    localparam logic [BEATS-1:0] POA_OVERRIDE_VAL = '1;

    // 1 = two-flop resync of sequencer levels, 0 = use levels directly
    localparam int LAT_CTL_RESYNC = 1;

endpackage
